/* Bender.yml */
package:
  name: ptw

sources:
  - ptw_pkg.sv
  - ptw_arbiter.sv
  - ptw_pte_cache.sv
  - ptw_walker.sv
  - ptw_regs.sv
  - ptw_top.sv
  - target: simulation
    files:
      - tb_ptw_wb_mem.sv
      - tb_ptw_top.sv

/* ptw.f */
ptw_pkg.sv
ptw_arbiter.sv
ptw_pte_cache.sv
ptw_walker.sv
ptw_regs.sv
ptw_top.sv
tb_ptw_wb_mem.sv
tb_ptw_top.sv

/* ptw_arbiter.sv */
module ptw_arbiter import ptw_pkg::*; #(
  parameter int N_PORTS = 3
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic [N_PORTS-1:0]             i_valid,
  input  logic [N_PORTS-1:0][VPN_W-1:0]  i_vpn,
  input  logic                           i_ready,
  output logic [N_PORTS-1:0]             o_grant,
  output logic [VPN_W-1:0]               o_vpn
);

  localparam int PTR_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

  logic [PTR_W-1:0]   r_ptr;
  logic [N_PORTS-1:0] w_pick;
  logic [PTR_W-1:0]   w_pick_idx;
  logic               w_found;

  // first valid port at or after the pointer wins
  always_comb begin
    int unsigned idx;
    w_pick     = '0;
    w_pick_idx = '0;
    w_found    = 1'b0;
    for (int i = 0; i < N_PORTS; i++) begin
      idx = (r_ptr + i) % N_PORTS;
      if (!w_found && i_valid[idx]) begin
        w_found     = 1'b1;
        w_pick[idx] = 1'b1;
        w_pick_idx  = PTR_W'(idx);
      end
    end
  end

  assign o_grant = i_ready ? w_pick : '0;
  assign o_vpn   = i_vpn[w_pick_idx];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ptr <= '0;
    end else if (|o_grant) begin
      r_ptr <= (w_pick_idx == PTR_W'(N_PORTS - 1)) ? '0 : w_pick_idx + 1'b1; // past the winner
    end
  end

  a_grant_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(o_grant));

endmodule

/* ptw_pkg.sv */
package ptw_pkg;

  // sv32 address geometry
  localparam int VPN_W       = 20;
  localparam int VPN_FIELD_W = 10;   // index bits per level
  localparam int PPN_W       = 22;
  localparam int PADDR_W     = 34;
  localparam int PTE_W       = 32;
  localparam int PG_IDX_W    = 12;
  localparam int LEVEL_W     = 1;    // level 1 is the root

  // pte flag positions
  localparam int PTE_V     = 0;
  localparam int PTE_R     = 1;
  localparam int PTE_W_BIT = 2;
  localparam int PTE_X     = 3;

  // register byte offsets
  localparam logic [3:0] REG_SATP   = 4'h0;
  localparam logic [3:0] REG_CTRL   = 4'h4;
  localparam logic [3:0] REG_WALKS  = 4'h8;   // read only
  localparam logic [3:0] REG_FAULTS = 4'hC;   // read only

  // control register bits
  localparam int CTRL_CACHE_EN = 0;
  localparam int CTRL_FLUSH    = 1;   // self clearing

endpackage

/* ptw_pte_cache.sv */
module ptw_pte_cache import ptw_pkg::*; #(
  parameter int CACHE_ENTRIES = 8
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_enable,
  input  logic               i_flush,
  input  logic               i_lookup,
  input  logic [PADDR_W-1:0] i_lookup_addr,
  output logic               o_hit,
  output logic [PTE_W-1:0]   o_pte,
  input  logic               i_fill,
  input  logic [PADDR_W-1:0] i_fill_addr,
  input  logic [PTE_W-1:0]   i_fill_pte
);

  localparam int OFS_W = $clog2(PTE_W / 8);   // byte offset within a pte
  localparam int IDX_W = (CACHE_ENTRIES > 1) ? $clog2(CACHE_ENTRIES) : 1;
  localparam int TAG_W = PADDR_W - OFS_W - IDX_W;

  logic [CACHE_ENTRIES-1:0] r_valid;
  logic [TAG_W-1:0]         r_tag  [CACHE_ENTRIES];
  logic [PTE_W-1:0]         r_data [CACHE_ENTRIES];

  logic [IDX_W-1:0] w_lookup_idx;
  logic [TAG_W-1:0] w_lookup_tag;
  logic [IDX_W-1:0] w_fill_idx;
  logic [TAG_W-1:0] w_fill_tag;

  assign w_lookup_idx = i_lookup_addr[OFS_W +: IDX_W];
  assign w_lookup_tag = i_lookup_addr[OFS_W + IDX_W +: TAG_W];
  assign w_fill_idx   = i_fill_addr[OFS_W +: IDX_W];
  assign w_fill_tag   = i_fill_addr[OFS_W + IDX_W +: TAG_W];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      o_hit   <= 1'b0;
    end else begin
      if (i_flush) begin
        r_valid <= '0;   // flush wins over a fill
      end else if (i_fill) begin
        r_valid[w_fill_idx] <= 1'b1;
      end
      o_hit <= i_lookup & i_enable & r_valid[w_lookup_idx] &
               (r_tag[w_lookup_idx] == w_lookup_tag);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill) begin
      r_tag[w_fill_idx]  <= w_fill_tag;
      r_data[w_fill_idx] <= i_fill_pte;
    end
    if (i_lookup) begin
      o_pte <= r_data[w_lookup_idx];
    end
  end

  // walker only fills from the memory state, never while looking up
  a_no_lookup_fill: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_lookup && i_fill));

endmodule

/* ptw_regs.sv */
module ptw_regs import ptw_pkg::*; (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_wbs_cyc,
  input  logic             i_wbs_stb,
  input  logic             i_wbs_we,
  input  logic [3:0]       i_wbs_adr,
  input  logic [PTE_W-1:0] i_wbs_dat,
  output logic [PTE_W-1:0] o_wbs_dat,
  output logic             o_wbs_ack,
  input  logic             i_walk_done,
  input  logic             i_walk_fault,
  output logic [PPN_W-1:0] o_root_ppn,
  output logic             o_cache_en,
  output logic             o_flush
);

  logic [PTE_W-1:0] r_walks;
  logic [PTE_W-1:0] r_faults;
  logic             w_access;
  logic             w_write;

  assign w_access = i_wbs_cyc & i_wbs_stb & !o_wbs_ack;   // one ack per access
  assign w_write  = w_access & i_wbs_we;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_wbs_ack  <= 1'b0;
      o_root_ppn <= '0;
      o_cache_en <= 1'b0;
      o_flush    <= 1'b0;
      r_walks    <= '0;
      r_faults   <= '0;
    end else begin
      o_wbs_ack <= w_access;
      o_flush   <= 1'b0;
      if (w_write) begin
        case (i_wbs_adr)
          REG_SATP: o_root_ppn <= i_wbs_dat[PPN_W-1:0];
          REG_CTRL: begin
            o_cache_en <= i_wbs_dat[CTRL_CACHE_EN];
            o_flush    <= i_wbs_dat[CTRL_FLUSH];
          end
          default: ;   // counters ignore writes
        endcase
      end
      if (i_walk_done && !(&r_walks)) r_walks <= r_walks + 1'b1;
      if (i_walk_done && i_walk_fault && !(&r_faults)) r_faults <= r_faults + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_access && !i_wbs_we) begin
      case (i_wbs_adr)
        REG_SATP:   o_wbs_dat <= PTE_W'(o_root_ppn);
        REG_CTRL:   o_wbs_dat <= PTE_W'(o_cache_en) << CTRL_CACHE_EN;  // flush reads as 0
        REG_WALKS:  o_wbs_dat <= r_walks;
        REG_FAULTS: o_wbs_dat <= r_faults;
        default:    o_wbs_dat <= '0;
      endcase
    end
  end

endmodule

/* ptw_top.sv */
module ptw_top import ptw_pkg::*; #(
  parameter int N_PORTS       = 3,
  parameter int CACHE_ENTRIES = 8
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  // clients
  input  logic [N_PORTS-1:0]            i_req_valid,
  input  logic [N_PORTS-1:0][VPN_W-1:0] i_req_vpn,
  output logic [N_PORTS-1:0]            o_req_ready,
  output logic [N_PORTS-1:0]            o_resp_valid,
  output logic [PTE_W-1:0]              o_resp_pte,
  output logic [LEVEL_W-1:0]            o_resp_level,
  output logic                          o_resp_fault,
  // wishbone master, reads only
  output logic                          o_wbm_cyc,
  output logic                          o_wbm_stb,
  output logic [PADDR_W-1:0]            o_wbm_adr,
  input  logic [PTE_W-1:0]              i_wbm_dat,
  input  logic                          i_wbm_ack,
  // wishbone slave, registers
  input  logic                          i_wbs_cyc,
  input  logic                          i_wbs_stb,
  input  logic                          i_wbs_we,
  input  logic [3:0]                    i_wbs_adr,
  input  logic [PTE_W-1:0]              i_wbs_dat,
  output logic [PTE_W-1:0]              o_wbs_dat,
  output logic                          o_wbs_ack
);

  logic               walker_ready;
  logic [VPN_W-1:0]   sel_vpn;
  logic               lookup;
  logic [PADDR_W-1:0] lookup_addr;
  logic               hit;
  logic [PTE_W-1:0]   cache_pte;
  logic               fill;
  logic [PTE_W-1:0]   fill_pte;
  logic               walk_done;
  logic               walk_fault;
  logic [PPN_W-1:0]   root_ppn;
  logic               cache_en;
  logic               flush;

  ptw_arbiter #(.N_PORTS(N_PORTS)) ptw_arbiter_inst (
    .i_clk, .i_reset_n,
    .i_valid (i_req_valid),
    .i_vpn   (i_req_vpn),
    .i_ready (walker_ready),
    .o_grant (o_req_ready),   // grant doubles as the per-port ready
    .o_vpn   (sel_vpn)
  );

  ptw_walker #(.N_PORTS(N_PORTS)) ptw_walker_inst (
    .i_clk, .i_reset_n,
    .i_grant       (o_req_ready),
    .i_vpn         (sel_vpn),
    .o_ready       (walker_ready),
    .i_root_ppn    (root_ppn),
    .o_lookup      (lookup),
    .o_lookup_addr (lookup_addr),
    .i_hit         (hit),
    .i_cache_pte   (cache_pte),
    .o_fill        (fill),
    .o_fill_pte    (fill_pte),
    .o_wbm_cyc, .o_wbm_stb, .o_wbm_adr, .i_wbm_dat, .i_wbm_ack,
    .o_resp_valid, .o_resp_pte, .o_resp_level, .o_resp_fault,
    .o_walk_done   (walk_done),
    .o_walk_fault  (walk_fault)
  );

  ptw_pte_cache #(.CACHE_ENTRIES(CACHE_ENTRIES)) ptw_pte_cache_inst (
    .i_clk, .i_reset_n,
    .i_enable      (cache_en),
    .i_flush       (flush),
    .i_lookup      (lookup),
    .i_lookup_addr (lookup_addr),
    .o_hit         (hit),
    .o_pte         (cache_pte),
    .i_fill        (fill),
    .i_fill_addr   (lookup_addr),   // walker address holds through the read
    .i_fill_pte    (fill_pte)
  );

  ptw_regs ptw_regs_inst (
    .i_clk, .i_reset_n,
    .i_wbs_cyc, .i_wbs_stb, .i_wbs_we, .i_wbs_adr, .i_wbs_dat, .o_wbs_dat, .o_wbs_ack,
    .i_walk_done  (walk_done),
    .i_walk_fault (walk_fault),
    .o_root_ppn   (root_ppn),
    .o_cache_en   (cache_en),
    .o_flush      (flush)
  );

endmodule

/* ptw_walker.sv */
module ptw_walker import ptw_pkg::*; #(
  parameter int N_PORTS = 3
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic [N_PORTS-1:0] i_grant,
  input  logic [VPN_W-1:0]   i_vpn,
  output logic               o_ready,
  input  logic [PPN_W-1:0]   i_root_ppn,
  output logic               o_lookup,
  output logic [PADDR_W-1:0] o_lookup_addr,
  input  logic               i_hit,
  input  logic [PTE_W-1:0]   i_cache_pte,
  output logic               o_fill,
  output logic [PTE_W-1:0]   o_fill_pte,
  output logic               o_wbm_cyc,
  output logic               o_wbm_stb,
  output logic [PADDR_W-1:0] o_wbm_adr,
  input  logic [PTE_W-1:0]   i_wbm_dat,
  input  logic               i_wbm_ack,
  output logic [N_PORTS-1:0] o_resp_valid,
  output logic [PTE_W-1:0]   o_resp_pte,
  output logic [LEVEL_W-1:0] o_resp_level,
  output logic               o_resp_fault,
  output logic               o_walk_done,
  output logic               o_walk_fault
);

  localparam int PPN_LSB = PTE_W - PPN_W;            // ppn sits above the flags
  localparam int OFS_W   = PG_IDX_W - VPN_FIELD_W;   // pte index is in words

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_CHECK,
    S_MEM,
    S_RESP
  } state_t;

  state_t               r_state;
  logic                 r_alive;   // idle is entered one cycle out of reset
  logic [N_PORTS-1:0]   r_port;
  logic [LEVEL_W-1:0]   r_level;
  logic                 r_from_mem;
  logic                 r_fault;
  logic [VPN_W-1:0]     r_vpn;
  logic [PADDR_W-1:0]   r_addr;
  logic [PTE_W-1:0]     r_pte;

  logic [PTE_W-1:0] w_pte;
  logic             w_leaf;
  logic             w_bad;
  logic             w_misaligned;
  logic             w_fault;
  logic             w_done;

  assign w_pte        = r_from_mem ? r_pte : i_cache_pte;
  assign w_leaf       = w_pte[PTE_R] | w_pte[PTE_X];
  assign w_bad        = !w_pte[PTE_V] | (w_pte[PTE_W_BIT] & !w_pte[PTE_R]);
  assign w_misaligned = w_leaf & (r_level == LEVEL_W'(1)) &
                        (w_pte[PPN_LSB +: VPN_FIELD_W] != '0);  // superpage ppn0
  assign w_fault      = w_bad | w_misaligned | (!w_leaf & (r_level == '0));
  assign w_done       = w_fault | w_leaf;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state    <= S_IDLE;
      r_alive    <= 1'b0;
      r_port     <= '0;
      r_level    <= '0;
      r_from_mem <= 1'b0;
      r_fault    <= 1'b0;
    end else begin
      r_alive <= 1'b1;
      case (r_state)
        S_IDLE: begin
          if (|i_grant) begin
            r_port     <= i_grant;
            r_level    <= LEVEL_W'(1);
            r_from_mem <= 1'b0;
            r_state    <= S_LOOKUP;
          end
        end
        S_LOOKUP: r_state <= S_CHECK;
        S_CHECK: begin
          if (!r_from_mem && !i_hit) begin
            r_state <= S_MEM;
          end else if (w_done) begin
            r_fault <= w_fault;
            r_state <= S_RESP;
          end else begin
            r_level    <= '0;
            r_from_mem <= 1'b0;
            r_state    <= S_LOOKUP;
          end
        end
        S_MEM: begin
          if (i_wbm_ack) begin
            r_from_mem <= 1'b1;
            r_state    <= S_CHECK;   // fill cycle doubles as the check
          end
        end
        S_RESP:  r_state <= S_IDLE;
        default: r_state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (r_state == S_IDLE && |i_grant) begin
      r_vpn  <= i_vpn;
      r_addr <= {i_root_ppn, i_vpn[VPN_W-1 -: VPN_FIELD_W], {OFS_W{1'b0}}};
    end
    if (r_state == S_CHECK && (r_from_mem || i_hit)) begin
      r_pte  <= w_pte;   // kept for the response
      r_addr <= {w_pte[PPN_LSB +: PPN_W], r_vpn[VPN_FIELD_W-1:0], {OFS_W{1'b0}}};
    end
    if (r_state == S_MEM && i_wbm_ack) begin
      r_pte <= i_wbm_dat;
    end
  end

  assign o_ready       = (r_state == S_IDLE) & r_alive;
  assign o_lookup      = (r_state == S_LOOKUP);
  assign o_lookup_addr = r_addr;

  assign o_fill     = (r_state == S_MEM) & i_wbm_ack;
  assign o_fill_pte = i_wbm_dat;

  assign o_wbm_cyc = (r_state == S_MEM);
  assign o_wbm_stb = (r_state == S_MEM);
  assign o_wbm_adr = r_addr;

  assign o_resp_valid = (r_state == S_RESP) ? r_port : '0;
  assign o_resp_pte   = r_pte;
  assign o_resp_level = r_level;
  assign o_resp_fault = r_fault;
  assign o_walk_done  = (r_state == S_RESP);
  assign o_walk_fault = r_fault;

  // a read in flight holds cyc, stb and its address until ack
  a_adr_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_wbm_stb && !i_wbm_ack |=> o_wbm_cyc && o_wbm_stb && $stable(o_wbm_adr));

endmodule

/* tb_ptw_top.sv */
module tb_ptw_top import ptw_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_PORTS   = 3;
  localparam int MEM_WORDS = 4096;
  localparam int N_ROWS    = 12;
  localparam int TIMEOUT   = 200;   // cycles per wait
  localparam logic [9:0] F_V = 10'(1 << PTE_V);
  localparam logic [9:0] F_R = 10'(1 << PTE_R);
  localparam logic [9:0] F_W = 10'(1 << PTE_W_BIT);
  localparam logic [9:0] F_X = 10'(1 << PTE_X);

  logic                          clk;
  logic                          reset_n;
  logic [N_PORTS-1:0]            req_valid;
  logic [N_PORTS-1:0][VPN_W-1:0] req_vpn;
  logic [N_PORTS-1:0]            req_ready;
  logic [N_PORTS-1:0]            resp_valid;
  logic [PTE_W-1:0]              resp_pte;
  logic [LEVEL_W-1:0]            resp_level;
  logic                          resp_fault;
  logic                          wbm_cyc;
  logic                          wbm_stb;
  logic [PADDR_W-1:0]            wbm_adr;
  logic [PTE_W-1:0]              wbm_dat;
  logic                          wbm_ack;
  logic                          wbs_cyc;
  logic                          wbs_stb;
  logic                          wbs_we;
  logic [3:0]                    wbs_adr;
  logic [PTE_W-1:0]              wbs_dat_w;
  logic [PTE_W-1:0]              wbs_dat_r;
  logic                          wbs_ack;

  string              tab_name  [N_ROWS];
  int                 tab_port  [N_ROWS];
  logic [VPN_W-1:0]   tab_vpn   [N_ROWS];
  logic [PTE_W-1:0]   tab_pte   [N_ROWS];
  logic [LEVEL_W-1:0] tab_level [N_ROWS];
  logic               tab_fault [N_ROWS];
  logic               tab_cache [N_ROWS];
  int                 row_total;
  int                 want_row  [N_PORTS];   // table row in flight per port

  int error_count;
  int check_count;
  int walk_count;
  int fault_count;
  int seed;

  ptw_top #(.N_PORTS(N_PORTS), .CACHE_ENTRIES(8)) ptw_top_inst (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_req_valid (req_valid), .i_req_vpn (req_vpn), .o_req_ready (req_ready),
    .o_resp_valid (resp_valid), .o_resp_pte (resp_pte),
    .o_resp_level (resp_level), .o_resp_fault (resp_fault),
    .o_wbm_cyc (wbm_cyc), .o_wbm_stb (wbm_stb), .o_wbm_adr (wbm_adr),
    .i_wbm_dat (wbm_dat), .i_wbm_ack (wbm_ack),
    .i_wbs_cyc (wbs_cyc), .i_wbs_stb (wbs_stb), .i_wbs_we (wbs_we), .i_wbs_adr (wbs_adr),
    .i_wbs_dat (wbs_dat_w), .o_wbs_dat (wbs_dat_r), .o_wbs_ack (wbs_ack)
  );

  tb_ptw_wb_mem #(.DEPTH(MEM_WORDS)) mem_inst (
    .i_clk (clk), .i_reset_n (reset_n), .i_cyc (wbm_cyc), .i_stb (wbm_stb),
    .i_adr (wbm_adr), .o_dat (wbm_dat), .o_ack (wbm_ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [PTE_W-1:0] make_pte(input logic [PPN_W-1:0] ppn,
                                                input logic [9:0] flags);
    return {ppn, flags};
  endfunction

  function automatic logic [VPN_W-1:0] make_vpn(input logic [9:0] hi, input logic [9:0] lo);
    return {hi, lo};
  endfunction

  function automatic logic [PTE_W-1:0] fill_word(input int unsigned idx);
    logic [PTE_W-1:0] w;
    w = (idx * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    w[PTE_V] = 1'b0;   // stray walks fault
    return w;
  endfunction

  task automatic put_pte(input int unsigned table_ppn, input int unsigned idx,
                         input logic [PTE_W-1:0] value);
    mem_inst.words[(table_ppn * 4096 + idx * 4) / 4] = value;
  endtask

  task automatic add_row(input string name, input int port, input logic [VPN_W-1:0] vpn,
                         input logic [PTE_W-1:0] pte, input logic [LEVEL_W-1:0] level,
                         input logic fault, input logic cache);
    tab_name[row_total]  = name;
    tab_port[row_total]  = port;
    tab_vpn[row_total]   = vpn;
    tab_pte[row_total]   = pte;
    tab_level[row_total] = level;
    tab_fault[row_total] = fault;
    tab_cache[row_total] = cache;
    row_total++;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic finish_run;
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
    error_count++;
    finish_run();
  endtask

  task automatic reg_access(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int   cycles;
    logic got;
    cycles    = 0;
    got       = 1'b0;
    rdata     = '0;
    wbs_cyc   = 1'b1;
    wbs_stb   = 1'b1;
    wbs_we    = we;
    wbs_adr   = adr;
    wbs_dat_w = wdata;
    while (!got && cycles < TIMEOUT) begin
      @(negedge clk);
      if (wbs_ack) begin
        got   = 1'b1;
        rdata = wbs_dat_r;
      end
      @(posedge clk);
      #2;
      cycles++;
    end
    wbs_cyc = 1'b0;
    wbs_stb = 1'b0;
    wbs_we  = 1'b0;
    if (!got) abort_on_timeout($sformatf("register ack at offset %h", adr));
  endtask

  // all ports in mask request at once, each waits for its single response
  task automatic run_walks(input logic [N_PORTS-1:0] mask);
    logic [N_PORTS-1:0] sent;
    logic [N_PORTS-1:0] taken;
    logic [N_PORTS-1:0] answered;
    int                 cycles;
    int                 r;
    sent     = '0;
    answered = '0;
    cycles   = 0;
    for (int p = 0; p < N_PORTS; p++) begin
      if (mask[p]) begin
        req_vpn[p] = tab_vpn[want_row[p]];
        walk_count++;
        if (tab_fault[want_row[p]]) fault_count++;
      end
    end
    req_valid = mask;
    while (answered != mask && cycles < TIMEOUT) begin
      @(negedge clk);
      taken = req_valid & req_ready;
      if ((resp_valid & (resp_valid - 1'b1)) != '0 ||
          (resp_valid & ~(sent & ~answered)) != '0) begin
        $display("response pulse %b arrived while only ports %b were waiting",
                 resp_valid, sent & ~answered);
        error_count++;
      end else begin
        for (int p = 0; p < N_PORTS; p++) begin
          if (resp_valid[p]) begin
            r = want_row[p];
            check_value($sformatf("%s pte", tab_name[r]), tab_pte[r], resp_pte);
            check_value($sformatf("%s level", tab_name[r]), 32'(tab_level[r]),
                        32'(resp_level));
            check_value($sformatf("%s fault", tab_name[r]), 32'(tab_fault[r]),
                        32'(resp_fault));
            answered[p] = 1'b1;
          end
        end
      end
      sent = sent | taken;
      @(posedge clk);
      #2;
      req_valid = req_valid & ~taken;   // hold low until the response
      cycles++;
    end
    if (answered != mask) abort_on_timeout($sformatf("walk responses on ports %b", mask));
  endtask

  task automatic load_tables;
    for (int i = 0; i < MEM_WORDS; i++) mem_inst.words[i] = fill_word(i);
    // root table at ppn 1, level 0 tables at ppn 2 and 3
    put_pte(1, 10'h001, make_pte(22'd2, F_V));
    put_pte(1, 10'h002, make_pte(22'd3, F_V));
    put_pte(1, 10'h010, make_pte(22'h000400, F_V | F_R | F_X));
    put_pte(1, 10'h011, make_pte(22'h000405, F_V | F_R));
    put_pte(1, 10'h020, make_pte(22'h000007, F_R | F_W));
    put_pte(1, 10'h021, make_pte(22'h000007, F_V | F_W));
    put_pte(2, 10'h003, make_pte(22'h012345, F_V | F_R | F_W | F_X));
    put_pte(2, 10'h004, make_pte(22'h000abc, F_V | F_R));
    put_pte(2, 10'h005, make_pte(22'h000005, F_V));   // pointer at the last level
    put_pte(2, 10'h006, make_pte(22'h000009, F_V | F_W));
    put_pte(3, 10'h07f, make_pte(22'h3fffff, F_V | F_X));
    put_pte(3, 10'h200, make_pte(22'h000002, F_R));
  endtask

  task automatic build_table;
    row_total = 0;
    add_row("leaf rwx", 0, make_vpn(10'h001, 10'h003),
            make_pte(22'h012345, F_V | F_R | F_W | F_X), 0, 0, 0);
    add_row("leaf r", 1, make_vpn(10'h001, 10'h004), make_pte(22'h000abc, F_V | F_R), 0, 0, 0);
    add_row("leaf x", 2, make_vpn(10'h002, 10'h07f), make_pte(22'h3fffff, F_V | F_X), 0, 0, 0);
    add_row("superpage", 0, make_vpn(10'h010, 10'h155),
            make_pte(22'h000400, F_V | F_R | F_X), 1, 0, 0);
    add_row("misaligned superpage", 1, make_vpn(10'h011, 10'h000),
            make_pte(22'h000405, F_V | F_R), 1, 1, 0);
    add_row("invalid l1", 2, make_vpn(10'h020, 10'h003), make_pte(22'h7, F_R | F_W), 1, 1, 0);
    add_row("w without r l1", 0, make_vpn(10'h021, 10'h0aa), make_pte(22'h7, F_V | F_W), 1, 1, 0);
    add_row("pointer at l0", 1, make_vpn(10'h001, 10'h005), make_pte(22'h5, F_V), 0, 1, 0);
    add_row("w without r l0", 2, make_vpn(10'h001, 10'h006), make_pte(22'h9, F_V | F_W), 0, 1, 0);
    add_row("invalid l0", 0, make_vpn(10'h002, 10'h200), make_pte(22'h2, F_R), 0, 1, 0);
    add_row("leaf rwx cached", 1, make_vpn(10'h001, 10'h003),
            make_pte(22'h012345, F_V | F_R | F_W | F_X), 0, 0, 1);
    add_row("superpage cached", 2, make_vpn(10'h010, 10'h155),
            make_pte(22'h000400, F_V | F_R | F_X), 1, 0, 1);
  endtask

  initial begin
    logic [31:0] rd;
    logic        cache_on;
    int          reads_before;
    int          cold;
    int          warm;
    int          order [N_PORTS];
    int          j;
    int          tmp;
    error_count = 0;
    check_count = 0;
    walk_count  = 0;
    fault_count = 0;
    seed        = 32'h873f_8d63;
    reset_n     = 1'b0;
    req_valid   = '0;
    req_vpn     = '0;
    wbs_cyc     = 1'b0;
    wbs_stb     = 1'b0;
    wbs_we      = 1'b0;
    wbs_adr     = '0;
    wbs_dat_w   = '0;
    load_tables();
    build_table();
    repeat (5) @(posedge clk);
    #2;
    reset_n = 1'b1;

    reg_access(1'b0, REG_WALKS, '0, rd);
    check_value("walks after reset", 0, rd);
    reg_access(1'b0, REG_FAULTS, '0, rd);
    check_value("faults after reset", 0, rd);
    reg_access(1'b0, REG_CTRL, '0, rd);
    check_value("ctrl after reset", 0, rd);
    reg_access(1'b1, REG_SATP, 32'h002a_5c3d, rd);
    reg_access(1'b0, REG_SATP, '0, rd);
    check_value("root ppn readback", 32'h002a_5c3d, rd);
    reg_access(1'b1, REG_CTRL, 32'(1) << CTRL_CACHE_EN, rd);
    reg_access(1'b0, REG_CTRL, '0, rd);
    check_value("ctrl readback", 32'(1) << CTRL_CACHE_EN, rd);
    reg_access(1'b1, REG_WALKS, 32'h0000_1234, rd);   // read only
    reg_access(1'b0, REG_WALKS, '0, rd);
    check_value("walks ignore writes", 0, rd);
    reg_access(1'b1, REG_CTRL, '0, rd);
    reg_access(1'b1, REG_SATP, 32'd1, rd);
    cache_on = 1'b0;

    for (int r = 0; r < row_total; r++) begin
      if (tab_cache[r] != cache_on) begin
        reg_access(1'b1, REG_CTRL, 32'(tab_cache[r]) << CTRL_CACHE_EN, rd);
        cache_on = tab_cache[r];
      end
      reads_before = mem_inst.read_count;
      want_row[tab_port[r]] = r;
      run_walks(N_PORTS'(1) << tab_port[r]);
      // without the cache every visited level reads memory once
      if (!tab_cache[r]) begin
        check_value($sformatf("%s reads", tab_name[r]), tab_level[r] ? 1 : 2,
                    mem_inst.read_count - reads_before);
      end
    end

    reg_access(1'b1, REG_CTRL, (32'(1) << CTRL_CACHE_EN) | (32'(1) << CTRL_FLUSH), rd);
    want_row[0]  = 0;
    reads_before = mem_inst.read_count;
    run_walks(3'b001);
    cold = mem_inst.read_count - reads_before;
    check_value("cold walk reads", 2, cold);
    reads_before = mem_inst.read_count;
    run_walks(3'b001);
    warm = mem_inst.read_count - reads_before;
    check_value("cached walk saves reads", 1, warm < cold);
    reg_access(1'b1, REG_CTRL, (32'(1) << CTRL_CACHE_EN) | (32'(1) << CTRL_FLUSH), rd);
    reads_before = mem_inst.read_count;
    run_walks(3'b001);
    check_value("reads after flush", 2, mem_inst.read_count - reads_before);

    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < N_PORTS; i++) order[i] = i;
      for (int i = N_PORTS - 1; i > 0; i--) begin
        j        = $unsigned($random(seed)) % (i + 1);
        tmp      = order[i];
        order[i] = order[j];
        order[j] = tmp;
      end
      for (int i = 0; i < N_PORTS; i++) want_row[order[i]] = (k * N_PORTS + i) % 10;
      run_walks('1);
    end

    reg_access(1'b0, REG_WALKS, '0, rd);
    check_value("walk counter", walk_count, rd);
    reg_access(1'b0, REG_FAULTS, '0, rd);
    check_value("fault counter", fault_count, rd);
    finish_run();
  end

endmodule

/* tb_ptw_wb_mem.sv */
module tb_ptw_wb_mem import ptw_pkg::*; #(
  parameter int DEPTH = 4096
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_cyc,
  input  logic               i_stb,
  input  logic [PADDR_W-1:0] i_adr,
  output logic [PTE_W-1:0]   o_dat,
  output logic               o_ack
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int AW = $clog2(DEPTH);

  logic [PTE_W-1:0] words [DEPTH];   // preloaded by the testbench
  int unsigned      read_count;
  int unsigned      wait_cnt;

  // ack latency rotates through 1 to 3 cycles
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ack      <= 1'b0;
      o_dat      <= '0;
      read_count <= 0;
      wait_cnt   <= 0;
    end else begin
      o_ack <= 1'b0;
      if (i_cyc && i_stb && !o_ack) begin
        if (wait_cnt >= read_count % 3) begin
          o_ack      <= 1'b1;
          o_dat      <= words[i_adr[AW+1:2]];   // word addressed
          read_count <= read_count + 1;
          wait_cnt   <= 0;
        end else begin
          wait_cnt <= wait_cnt + 1;
        end
      end
    end
  end

endmodule
